//--- hdl/io_pkg.sv
package io_pkg;

    localparam int io_word_w = 32;
    localparam int uart_byte_w = 8;

    typedef logic [io_word_w-1:0] io_word_t;
    typedef logic [uart_byte_w-1:0] uart_byte_t;

    // word addresses of the memory-mapped I/O space
    localparam io_word_t io_uart_ctrl = 32'h8000_0000;
    localparam io_word_t io_uart_rdata = 32'h8000_0004;
    localparam io_word_t io_uart_tdata = 32'h8000_0008;
    localparam io_word_t io_cycle_cnt = 32'h8000_0010;
    localparam io_word_t io_inst_cnt = 32'h8000_0014;
    localparam io_word_t io_rst_cnt = 32'h8000_0018;
    localparam io_word_t io_br_inst_cnt = 32'h8000_001c;
    localparam io_word_t io_br_suc_cnt = 32'h8000_0020;

    // one CPU access, issued at most once per cycle
    typedef struct packed {
        logic en;
        io_word_t addr;
        io_word_t wdata;
    } io_req_t;

    // per-cycle strobes from the pipeline
    typedef struct packed {
        logic inst_ret;
        logic br_inst;
        logic br_suc;
    } perf_event_t;

    typedef struct packed {
        io_word_t cycle;
        io_word_t inst;
        io_word_t br_inst;
        io_word_t br_suc;
    } perf_counts_t;

endpackage

//--- hdl/uart_tx.sv
module uart_tx import io_pkg::*; #(
    parameter int clock_freq = 125_000_000,
    parameter int baud_rate = 115_200
) (
    input logic clk,
    input logic rst,
    input uart_byte_t data,
    input logic valid,
    output logic ready,
    output logic serial_out
);

    localparam int clocks_per_bit = clock_freq / baud_rate;
    localparam int cnt_w = $clog2(clocks_per_bit + 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clocks_per_bit - 1);
    localparam int frame_w = uart_byte_w + 2;

    logic busy;
    logic [cnt_w-1:0] clk_cnt;
    logic [3:0] bit_cnt;
    logic [frame_w-1:0] shift;

    // the shift register refills with ones as it empties, so the line rests high
    assign serial_out = shift[0];
    assign ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shift <= '1;
        end else if (!busy) begin
            if (valid) begin
                // stop bit, data LSB first, start bit
                busy <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
                shift <= {1'b1, data, 1'b0};
            end
        end else if (clk_cnt == last_cnt) begin
            clk_cnt <= '0;
            shift <= {1'b1, shift[frame_w-1:1]};
            if (bit_cnt == 4'(frame_w - 1)) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    idle_line_a: assert property (
        @(posedge clk) disable iff (rst) !busy |-> serial_out
    );

endmodule

//--- hdl/uart_rx.sv
module uart_rx import io_pkg::*; #(
    parameter int clock_freq = 125_000_000,
    parameter int baud_rate = 115_200
) (
    input logic clk,
    input logic rst,
    input logic serial_in,
    output uart_byte_t data,
    output logic strobe
);

    localparam int clocks_per_bit = clock_freq / baud_rate;
    localparam int cnt_w = $clog2(clocks_per_bit + 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clocks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clocks_per_bit / 2);
    localparam logic [3:0] stop_idx = 4'(uart_byte_w + 1);

    logic [1:0] sync;
    logic line;
    logic line_q;
    logic busy;
    logic [cnt_w-1:0] clk_cnt;
    logic [3:0] bit_cnt;

    assign line = sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= 2'b11;
            line_q <= 1'b1;
            busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            strobe <= 1'b0;
        end else begin
            sync <= {sync[0], serial_in};
            line_q <= line;
            strobe <= 1'b0;
            if (!busy) begin
                // starting half way through the count lands every sample near mid-bit
                if (line_q && !line) begin
                    busy <= 1'b1;
                    clk_cnt <= half_cnt;
                    bit_cnt <= '0;
                end
            end else if (clk_cnt == last_cnt) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd0) begin
                    // a start bit that is high again at mid-bit was a glitch
                    if (line) begin
                        busy <= 1'b0;
                    end else begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt == stop_idx) begin
                    busy <= 1'b0;
                    strobe <= line;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // data bits arrive LSB first and shift in from the top
    always_ff @(posedge clk) begin
        if (busy && clk_cnt == last_cnt && bit_cnt != 4'd0 && bit_cnt != stop_idx) begin
            data <= {line, data[uart_byte_w-1:1]};
        end
    end

    single_strobe_a: assert property (
        @(posedge clk) disable iff (rst) strobe |=> !strobe
    );

endmodule

//--- hdl/uart.sv
module uart import io_pkg::*; #(
    parameter int clock_freq = 125_000_000,
    parameter int baud_rate = 115_200
) (
    input logic clk,
    input logic rst,
    input uart_byte_t tx_data,
    input logic tx_valid,
    input logic rx_ready,
    input logic serial_in,
    output logic tx_ready,
    output uart_byte_t rx_data,
    output logic rx_valid,
    output logic serial_out
);

    uart_byte_t rx_byte;
    logic rx_strobe;
    logic full;

    uart_tx #(
        .clock_freq(clock_freq),
        .baud_rate(baud_rate)
    ) u_tx (
        .clk(clk),
        .rst(rst),
        .data(tx_data),
        .valid(tx_valid),
        .ready(tx_ready),
        .serial_out(serial_out)
    );

    uart_rx #(
        .clock_freq(clock_freq),
        .baud_rate(baud_rate)
    ) u_rx (
        .clk(clk),
        .rst(rst),
        .serial_in(serial_in),
        .data(rx_byte),
        .strobe(rx_strobe)
    );

    // one-byte holding buffer, a fresh byte overwrites one not yet taken
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
            rx_data <= '0;
        end else if (rx_strobe) begin
            full <= 1'b1;
            rx_data <= rx_byte;
        end else if (rx_valid && rx_ready) begin
            full <= 1'b0;
        end
    end

    assign rx_valid = full;

endmodule

//--- hdl/perf_counters.sv
module perf_counters import io_pkg::*; (
    input logic clk,
    input logic rst,
    input logic clear,
    input perf_event_t events,
    output perf_counts_t counts
);

    perf_counts_t next_counts;

    // all counters wrap around at 2^32
    always_comb begin
        next_counts.cycle = counts.cycle + 32'd1;
        next_counts.inst = counts.inst;
        next_counts.br_inst = counts.br_inst;
        next_counts.br_suc = counts.br_suc;

        if (events.inst_ret) begin
            next_counts.inst = counts.inst + 32'd1;
        end
        if (events.br_inst) begin
            next_counts.br_inst = counts.br_inst + 32'd1;
        end
        if (events.br_suc) begin
            next_counts.br_suc = counts.br_suc + 32'd1;
        end
    end

    // clear beats any event seen in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            counts <= '0;
        end else begin
            counts <= next_counts;
        end
    end

endmodule

//--- hdl/io_regs.sv
module io_regs import io_pkg::*; (
    input logic clk,
    input logic rst,
    input io_req_t req,
    input perf_counts_t counts,
    input logic tx_ready,
    input uart_byte_t rx_data,
    input logic rx_valid,
    output io_word_t dout,
    output uart_byte_t tx_data,
    output logic tx_valid,
    output logic rx_ready,
    output logic counts_clear
);

    io_word_t next_dout;
    logic next_tx_valid;
    logic next_can_read;
    logic can_read;
    logic tx_write;

    // clear is decoded straight from the request so the counters see it in the same cycle
    assign counts_clear = req.en && (req.addr == io_rst_cnt);
    assign tx_write = req.en && (req.addr == io_uart_tdata);

    always_comb begin
        next_dout = '0;
        next_tx_valid = tx_valid;
        next_can_read = can_read;

        if (rx_valid) begin
            next_can_read = 1'b1;
        end
        if (tx_valid && tx_ready) begin
            next_tx_valid = 1'b0;
        end
        if (tx_write) begin
            next_tx_valid = 1'b1;
        end

        if (req.en) begin
            case (req.addr)
                io_uart_ctrl: begin
                    next_dout = {30'b0, rx_valid | can_read, tx_ready};
                end
                io_uart_rdata: begin
                    next_dout = {24'b0, rx_data};
                    next_can_read = 1'b0;
                end
                io_cycle_cnt: begin
                    next_dout = counts.cycle;
                end
                io_inst_cnt: begin
                    next_dout = counts.inst;
                end
                io_br_inst_cnt: begin
                    next_dout = counts.br_inst;
                end
                io_br_suc_cnt: begin
                    next_dout = counts.br_suc;
                end
                // writes, the clear and unmapped addresses all read as zero
                default: begin
                    next_dout = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
            tx_valid <= 1'b0;
            rx_ready <= 1'b0;
            can_read <= 1'b0;
        end else begin
            dout <= next_dout;
            tx_valid <= next_tx_valid;
            rx_ready <= 1'b1;
            can_read <= next_can_read;
        end
    end

    // a pending byte is replaced by a later write but never lost while the shift is busy
    always_ff @(posedge clk) begin
        if (tx_write) begin
            tx_data <= req.wdata[uart_byte_w-1:0];
        end
    end

    tx_hold_a: assert property (
        @(posedge clk) disable iff (rst) tx_valid && !tx_ready |=> tx_valid
    );

endmodule

//--- hdl/io_top.sv
module io_top import io_pkg::*; #(
    parameter int clock_freq = 125_000_000,
    parameter int baud_rate = 115_200
) (
    input logic clk,
    input logic rst,
    input io_req_t req,
    input perf_event_t events,
    input logic serial_in,
    output logic serial_out,
    output io_word_t dout
);

    uart_byte_t tx_data;
    logic tx_valid;
    logic tx_ready;
    uart_byte_t rx_data;
    logic rx_valid;
    logic rx_ready;
    logic counts_clear;
    perf_counts_t counts;

    io_regs u_regs (
        .clk(clk),
        .rst(rst),
        .req(req),
        .counts(counts),
        .tx_ready(tx_ready),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .dout(dout),
        .tx_data(tx_data),
        .tx_valid(tx_valid),
        .rx_ready(rx_ready),
        .counts_clear(counts_clear)
    );

    uart #(
        .clock_freq(clock_freq),
        .baud_rate(baud_rate)
    ) u_uart (
        .clk(clk),
        .rst(rst),
        .tx_data(tx_data),
        .tx_valid(tx_valid),
        .rx_ready(rx_ready),
        .serial_in(serial_in),
        .tx_ready(tx_ready),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .serial_out(serial_out)
    );

    perf_counters u_counters (
        .clk(clk),
        .rst(rst),
        .clear(counts_clear),
        .events(events),
        .counts(counts)
    );

endmodule

//--- verif/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 10;
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verif/io_tb.sv
module io_tb import io_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clock_freq = 50_000_000;
    localparam int baud_rate = 5_000_000;
    localparam int clocks_per_bit = clock_freq / baud_rate;
    localparam int timeout_cycles = 20_000;
    localparam int event_cycles = 200;
    localparam int frame_count = 6;
    localparam io_word_t unmapped_addr = 32'h8000_0024;

    logic clk;
    logic rst;
    io_req_t req;
    perf_event_t events;
    logic serial_in;
    logic serial_out;
    io_word_t dout;

    integer seed = 32'h1985_d0dd;
    int cycle_no = 0;

    // expected counters follow the strobes that were driven
    perf_counts_t model_counts;
    uart_byte_t model_rx_byte = '0;

    logic pend_check = 1'b0;
    io_word_t pend_addr;
    io_word_t pend_word;

    uart_byte_t tx_expect[$];
    uart_byte_t tx_seen[$];

    tb_clock clock_gen (
        .clk(clk),
        .rst(rst)
    );

    io_top #(
        .clock_freq(clock_freq),
        .baud_rate(baud_rate)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .req(req),
        .events(events),
        .serial_in(serial_in),
        .serial_out(serial_out),
        .dout(dout)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input io_word_t actual, input io_word_t expected,
                              input string what);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0d ns: %s is 0x%08h, expected 0x%08h",
                $time, what, actual, expected));
        end
    endtask

    task automatic check_byte(input uart_byte_t actual, input uart_byte_t expected,
                              input string what);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0d ns: %s is 0x%02h, expected 0x%02h",
                $time, what, actual, expected));
        end
    endtask

    function automatic io_word_t io_expect(input io_word_t addr, input perf_counts_t counts,
                                           input uart_byte_t rx_byte);
        case (addr)
            // status of a quiet UART, transmitter idle and nothing received
            io_uart_ctrl: return 32'h0000_0001;
            io_uart_rdata: return {24'h0, rx_byte};
            io_cycle_cnt: return counts.cycle;
            io_inst_cnt: return counts.inst;
            io_br_inst_cnt: return counts.br_inst;
            io_br_suc_cnt: return counts.br_suc;
            default: return '0;
        endcase
    endfunction

    // the expected word is taken from the counters before this edge updates them
    always @(posedge clk) begin
        if (rst) begin
            pend_check = 1'b1;
            pend_addr = '0;
            pend_word = '0;
            model_counts = '0;
        end else begin
            // the status word depends on line timing and is checked by the polling code
            pend_check = !(req.en && req.addr == io_uart_ctrl);
            pend_addr = req.addr;
            pend_word = req.en ? io_expect(req.addr, model_counts, model_rx_byte) : '0;
            if (req.en && req.addr == io_rst_cnt) begin
                model_counts = '0;
            end else begin
                model_counts.cycle = model_counts.cycle + 32'd1;
                if (events.inst_ret) begin
                    model_counts.inst = model_counts.inst + 32'd1;
                end
                if (events.br_inst) begin
                    model_counts.br_inst = model_counts.br_inst + 32'd1;
                end
                if (events.br_suc) begin
                    model_counts.br_suc = model_counts.br_suc + 32'd1;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (pend_check) begin
            check_word(dout, pend_word, $sformatf("dout after access to 0x%08h", pend_addr));
        end
    end

    always @(posedge clk) begin
        cycle_no <= cycle_no + 1;
        if (cycle_no >= timeout_cycles) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles",
                timeout_cycles));
        end
    end

    // decodes 8N1 frames on serial_out, sampling near the middle of each bit
    initial begin : tx_monitor
        uart_byte_t data;

        forever begin
            @(negedge clk);
            if (!rst && serial_out === 1'b0) begin
                repeat (clocks_per_bit / 2 - 1) @(negedge clk);
                if (serial_out !== 1'b0) begin
                    fail_run("Start bit on serial_out ended before the middle of the bit");
                end
                for (int i = 0; i < uart_byte_w; i++) begin
                    repeat (clocks_per_bit) @(negedge clk);
                    data[i] = serial_out;
                end
                repeat (clocks_per_bit) @(negedge clk);
                if (serial_out !== 1'b1) begin
                    fail_run("Stop bit on serial_out was low, the frame is broken");
                end
                tx_seen.push_back(data);
            end
        end
    end

    task automatic read_word(input io_word_t addr, output io_word_t data);
        @(posedge clk);
        req <= '{en: 1'b1, addr: addr, wdata: '0};
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        data = dout;
    endtask

    task automatic write_word(input io_word_t addr, input io_word_t wdata);
        @(posedge clk);
        req <= '{en: 1'b1, addr: addr, wdata: wdata};
        @(posedge clk);
        req <= '0;
    endtask

    task automatic wait_status_bit(input int bit_idx);
        io_word_t status;

        do begin
            read_word(io_uart_ctrl, status);
        end while (status[bit_idx] == 1'b0);
    endtask

    task automatic send_serial(input uart_byte_t data);
        logic [9:0] frame;

        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            serial_in <= frame[i];
            repeat (clocks_per_bit - 1) @(posedge clk);
        end
        @(negedge clk);
        model_rx_byte = data;
    endtask

    initial begin : stimulus
        io_word_t got;
        io_word_t rand_word;
        uart_byte_t data;

        req = '0;
        events = '0;
        serial_in = 1'b1;
        @(negedge rst);

        read_word(io_inst_cnt, got);
        check_word(got, '0, "retired instruction count after reset");
        read_word(io_br_inst_cnt, got);
        check_word(got, '0, "branch count after reset");
        read_word(io_br_suc_cnt, got);
        check_word(got, '0, "taken branch count after reset");
        read_word(io_cycle_cnt, got);
        read_word(io_uart_rdata, got);
        check_word(got, '0, "receive data after reset");
        read_word(io_uart_ctrl, got);
        check_word(got, io_expect(io_uart_ctrl, model_counts, model_rx_byte),
            "status after reset");

        write_word(io_rst_cnt, '0);
        for (int n = 0; n < event_cycles; n++) begin
            @(posedge clk);
            rand_word = $random(seed);
            events <= rand_word[2:0];
        end
        @(posedge clk);
        events <= '0;
        read_word(io_cycle_cnt, got);
        read_word(io_inst_cnt, got);
        read_word(io_br_inst_cnt, got);
        read_word(io_br_suc_cnt, got);

        // upper write data bits are random too, only the low byte goes out
        for (int n = 0; n < frame_count; n++) begin
            rand_word = $random(seed);
            wait_status_bit(0);
            write_word(io_uart_tdata, rand_word);
            tx_expect.push_back(rand_word[7:0]);
        end
        while (tx_seen.size() < frame_count) begin
            @(posedge clk);
        end
        for (int n = 0; n < frame_count; n++) begin
            check_byte(tx_seen.pop_front(), tx_expect.pop_front(),
                $sformatf("transmitted byte %0d", n));
        end

        for (int n = 0; n < frame_count; n++) begin
            rand_word = $random(seed);
            data = rand_word[7:0];
            send_serial(data);
            wait_status_bit(1);
            read_word(io_uart_rdata, got);
            check_byte(got[7:0], data, $sformatf("received byte %0d", n));
            read_word(io_uart_ctrl, got);
            check_word(got, io_expect(io_uart_ctrl, model_counts, model_rx_byte),
                "status after taking the received byte");
        end

        read_word(unmapped_addr, got);
        check_word(got, '0, "read of an unmapped address");
        write_word(io_rst_cnt, '0);
        read_word(io_cycle_cnt, got);

        repeat (2) @(posedge clk);
        if (tx_seen.size() != 0) begin
            fail_run("serial_out carried more frames than were written");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- sources.f
hdl/io_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart.sv
hdl/perf_counters.sv
hdl/io_regs.sv
hdl/io_top.sv
verif/tb_clock.sv
verif/io_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the I/O block testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module io_tb \
    -f sources.f \
    -o io_sim

# a $fatal in the testbench ends the run with a failing status
./obj_dir/io_sim
